// File: source/rx_data_pkg.sv
package rx_data_pkg;

    // interleaving factor of the receiver ADC
    parameter int n_ti = 16;

    // magnitude bits per slice
    parameter int n_adc = 8;

    // prbs history length, enough for prbs7
    parameter int n_prbs = 7;

    // raw slice magnitude as it leaves the ADC
    typedef logic [n_adc-1:0] adc_mag_t;

    // unfolded code, also used for offsets and the slicer threshold
    typedef logic signed [n_adc-1:0] adc_code_t;

    // one bit per slice
    typedef logic [n_ti-1:0] lane_bits_t;

    // tap mask, bit t-1 marks the stream bit t positions back
    typedef logic [n_prbs-1:0] prbs_eqn_t;

    // error and checked-bit counters
    typedef logic [31:0] count_t;

endpackage

// File: source/rx_ctl_pkg.sv
package rx_ctl_pkg;

    // phase interpolator code width
    parameter int n_pi = 9;

    // number of PI outputs towards the analog core
    parameter int n_out = 4;

    // PI control code
    typedef logic [n_pi-1:0] pi_code_t;

    // max mux selection, scale grows in steps of 16
    typedef logic [n_pi-5:0] pi_sel_t;

    // prbs checker states
    typedef enum logic [0:0] {
        CHK_FILL = 1'b0,
        CHK_RUN  = 1'b1
    } chk_state_t;

endpackage

// File: source/adc_unfold_slice.sv
`timescale 1ns/1ns

module adc_unfold_slice #(
    parameter int n_lanes = 16,
    parameter int n_bits  = 8
) (
    input  logic                    clk_adc,
    input  logic                    cdr_rstb,
    input  rx_data_pkg::adc_mag_t   adc_mag_i [n_lanes-1:0],
    input  rx_data_pkg::lane_bits_t adc_sign_i,
    input  rx_data_pkg::adc_code_t  pfd_offset_i [n_lanes-1:0],
    input  rx_data_pkg::adc_code_t  slice_thresh_i,
    output rx_data_pkg::lane_bits_t rx_bits_o
);
    import rx_data_pkg::*;

    // two guard bits hold +-mag minus offset without overflow
    localparam int ext_w = n_bits + 2;
    localparam logic signed [ext_w-1:0] code_max = (2 ** (n_bits - 1)) - 1;
    localparam logic signed [ext_w-1:0] code_min = -(2 ** (n_bits - 1));

    logic signed [ext_w-1:0] signed_val [n_lanes-1:0];
    logic signed [ext_w-1:0] shifted_val [n_lanes-1:0];
    adc_code_t               unf_d [n_lanes-1:0];
    adc_code_t               unf_q [n_lanes-1:0];
    lane_bits_t              bits_d;
    lane_bits_t              bits_q;

    //////////////////////////////////////////////////
    // stage one, unfold and remove offset
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < n_lanes; k++) begin
            // sign bit high means a positive sample
            if (adc_sign_i[k]) begin
                signed_val[k] = $signed(ext_w'(adc_mag_i[k]));
            end else begin
                signed_val[k] = -$signed(ext_w'(adc_mag_i[k]));
            end
            shifted_val[k] = signed_val[k] - ext_w'(pfd_offset_i[k]);

            // saturate into the code range
            if (shifted_val[k] > code_max) begin
                unf_d[k] = code_max[n_bits-1:0];
            end else if (shifted_val[k] < code_min) begin
                unf_d[k] = code_min[n_bits-1:0];
            end else begin
                unf_d[k] = shifted_val[k][n_bits-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // stage two, slicer
    //////////////////////////////////////////////////

    always_comb begin
        bits_d = '0;
        for (int k = 0; k < n_lanes; k++) begin
            // signed compare against the common threshold
            bits_d[k] = (unf_q[k] > slice_thresh_i);
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            unf_q  <= '{default: '0};
            bits_q <= '0;
        end else begin
            unf_q  <= unf_d;
            bits_q <= bits_d;
        end
    end

    assign rx_bits_o = bits_q;

endmodule

// File: source/prbs_checker.sv
`timescale 1ns/1ns

module prbs_checker #(
    parameter int n_lanes = 16,
    parameter int n_hist  = 7
) (
    input  logic                    clk_adc,
    input  logic                    cdr_rstb,
    input  rx_data_pkg::lane_bits_t rx_bits_i,
    input  rx_data_pkg::prbs_eqn_t  prbs_eqn_i,
    input  rx_data_pkg::lane_bits_t prbs_chan_sel_i,
    input  logic                    prbs_cke_i,
    input  logic                    prbs_clear_i,
    output rx_data_pkg::lane_bits_t prbs_flags_o,
    output rx_data_pkg::count_t     err_bits_o,
    output rx_data_pkg::count_t     total_bits_o
);
    import rx_data_pkg::*;
    import rx_ctl_pkg::*;

    chk_state_t                state_q;
    logic [n_hist-1:0]         hist_q;
    logic [n_hist+n_lanes-1:0] stream;
    lane_bits_t                pred_vec;
    lane_bits_t                err_vec;
    lane_bits_t                flags_q;
    count_t                    err_inc;
    count_t                    bit_inc;
    count_t                    err_q;
    count_t                    total_q;

    // chronological view, oldest history bit at index 0
    // lane 0 of the new word follows the last bit of the previous one
    assign stream = {rx_bits_i, hist_q};

    //////////////////////////////////////////////////
    // prediction from received bits
    //////////////////////////////////////////////////

    always_comb begin
        pred_vec = '0;
        for (int k = 0; k < n_lanes; k++) begin
            for (int t = 1; t <= n_hist; t++) begin
                // tap t looks t stream positions back
                if (prbs_eqn_i[t-1]) begin
                    pred_vec[k] = pred_vec[k] ^ stream[n_hist+k-t];
                end
            end
        end
    end

    assign err_vec = pred_vec ^ rx_bits_i;

    // per-word increments over the selected lanes
    always_comb begin
        err_inc = '0;
        bit_inc = '0;
        for (int k = 0; k < n_lanes; k++) begin
            err_inc = err_inc + count_t'(err_vec[k] & prbs_chan_sel_i[k]);
            bit_inc = bit_inc + count_t'(prbs_chan_sel_i[k]);
        end
    end

    //////////////////////////////////////////////////
    // state, history and counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= CHK_FILL;
            hist_q  <= '0;
            flags_q <= '0;
            err_q   <= '0;
            total_q <= '0;
        end else if (prbs_clear_i) begin
            // history is reloaded by the next fill word
            state_q <= CHK_FILL;
            flags_q <= '0;
            err_q   <= '0;
            total_q <= '0;
        end else if (prbs_cke_i) begin
            hist_q <= stream[n_hist+n_lanes-1 -: n_hist];
            case (state_q)
                CHK_FILL: begin
                    state_q <= CHK_RUN;
                end
                CHK_RUN: begin
                    flags_q <= err_vec;
                    err_q   <= err_q + err_inc;
                    total_q <= total_q + bit_inc;
                end
                default: begin
                    state_q <= CHK_FILL;
                end
            endcase
        end
    end

    assign prbs_flags_o = flags_q;
    assign err_bits_o   = err_q;
    assign total_bits_o = total_q;

endmodule

// File: source/pi_ctl_scaler.sv
`timescale 1ns/1ns

module pi_ctl_scaler #(
    parameter int n_outputs   = 4,
    parameter int wait_cycles = 32
) (
    input  logic                 clk_adc,
    input  logic                 cdr_rstb,
    input  rx_ctl_pkg::pi_code_t pi_ctl_i [n_outputs-1:0],
    input  rx_ctl_pkg::pi_code_t pi_offset_i [n_outputs-1:0],
    input  rx_ctl_pkg::pi_sel_t  max_sel_i [n_outputs-1:0],
    input  logic [n_outputs-1:0] bypass_en_i,
    input  rx_ctl_pkg::pi_code_t bypass_ctl_i [n_outputs-1:0],
    output logic                 ctl_valid_o,
    output rx_ctl_pkg::pi_code_t int_pi_ctl_o [n_outputs-1:0]
);
    import rx_ctl_pkg::*;

    localparam int code_w    = $bits(pi_code_t);
    localparam int prod_w    = 2 * code_w;
    localparam int sel_shift = code_w - $bits(pi_sel_t);
    localparam int cnt_w     = $clog2(wait_cycles + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(wait_cycles - 1);

    logic [cnt_w-1:0]  wait_cnt_q;
    logic              ctl_valid_q;
    logic              ctl_valid_d;
    pi_code_t          scale_val [n_outputs-1:0];
    pi_code_t          unscaled [n_outputs-1:0];
    logic [prod_w-1:0] scaled [n_outputs-1:0];
    pi_code_t          code_d [n_outputs-1:0];
    pi_code_t          code_q [n_outputs-1:0];

    //////////////////////////////////////////////////
    // post-reset wait
    //////////////////////////////////////////////////

    // goes high on the same edge that sees the counter at its last value
    assign ctl_valid_d = ctl_valid_q | (wait_cnt_q == cnt_last);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt_q  <= '0;
            ctl_valid_q <= 1'b0;
        end else begin
            if (wait_cnt_q != cnt_last) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
            ctl_valid_q <= ctl_valid_d;
        end
    end

    //////////////////////////////////////////////////
    // scaling and bypass
    //////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < n_outputs; j++) begin
            // (sel + 1) * 16 - 1, exact since the top value is 511
            scale_val[j] = ((pi_code_t'(max_sel_i[j]) + 1'b1) << sel_shift) - 1'b1;
            // offset wraps within the code width
            unscaled[j]  = pi_ctl_i[j] + pi_offset_i[j];
            scaled[j]    = prod_w'(unscaled[j]) * prod_w'(scale_val[j]);
            if (bypass_en_i[j]) begin
                code_d[j] = bypass_ctl_i[j];
            end else begin
                code_d[j] = scaled[j][prod_w-1:code_w];
            end
        end
    end

    // codes follow valid, so nothing reaches the PIs before the wait ends
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            code_q <= '{default: '0};
        end else if (ctl_valid_d) begin
            code_q <= code_d;
        end else begin
            code_q <= '{default: '0};
        end
    end

    assign ctl_valid_o  = ctl_valid_q;
    assign int_pi_ctl_o = code_q;

endmodule

// File: source/digital_core.sv
`timescale 1ns/1ns

module digital_core #(
    parameter int n_lanes     = rx_data_pkg::n_ti,
    parameter int n_bits      = rx_data_pkg::n_adc,
    parameter int n_hist      = rx_data_pkg::n_prbs,
    parameter int n_outputs   = rx_ctl_pkg::n_out,
    parameter int wait_cycles = 32
) (
    input  logic                    clk_adc,
    input  logic                    cdr_rstb,

    // ADC slices
    input  rx_data_pkg::adc_mag_t   adc_mag_i [n_lanes-1:0],
    input  rx_data_pkg::lane_bits_t adc_sign_i,
    input  rx_data_pkg::adc_code_t  pfd_offset_i [n_lanes-1:0],
    input  rx_data_pkg::adc_code_t  slice_thresh_i,

    // prbs checker configuration
    input  rx_data_pkg::prbs_eqn_t  prbs_eqn_i,
    input  rx_data_pkg::lane_bits_t prbs_chan_sel_i,
    input  logic                    prbs_cke_i,
    input  logic                    prbs_clear_i,

    // phase interpolator control
    input  rx_ctl_pkg::pi_code_t    pi_ctl_i [n_outputs-1:0],
    input  rx_ctl_pkg::pi_code_t    pi_offset_i [n_outputs-1:0],
    input  rx_ctl_pkg::pi_sel_t     max_sel_i [n_outputs-1:0],
    input  logic [n_outputs-1:0]    bypass_en_i,
    input  rx_ctl_pkg::pi_code_t    bypass_ctl_i [n_outputs-1:0],

    output rx_data_pkg::lane_bits_t rx_bits_o,
    output rx_data_pkg::lane_bits_t prbs_flags_o,
    output rx_data_pkg::count_t     err_bits_o,
    output rx_data_pkg::count_t     total_bits_o,
    output logic                    ctl_valid_o,
    output rx_ctl_pkg::pi_code_t    int_pi_ctl_o [n_outputs-1:0]
);
    import rx_data_pkg::*;

    // recovered bit word, shared by the checker and the port
    lane_bits_t rx_bits;

    //////////////////////////////////////////////////
    // sample path
    //////////////////////////////////////////////////

    adc_unfold_slice #(
        .n_lanes(n_lanes),
        .n_bits (n_bits)
    ) u_unfold_slice (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_mag_i     (adc_mag_i),
        .adc_sign_i    (adc_sign_i),
        .pfd_offset_i  (pfd_offset_i),
        .slice_thresh_i(slice_thresh_i),
        .rx_bits_o     (rx_bits)
    );

    assign rx_bits_o = rx_bits;

    prbs_checker #(
        .n_lanes(n_lanes),
        .n_hist (n_hist)
    ) u_prbs_checker (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .rx_bits_i      (rx_bits),
        .prbs_eqn_i     (prbs_eqn_i),
        .prbs_chan_sel_i(prbs_chan_sel_i),
        .prbs_cke_i     (prbs_cke_i),
        .prbs_clear_i   (prbs_clear_i),
        .prbs_flags_o   (prbs_flags_o),
        .err_bits_o     (err_bits_o),
        .total_bits_o   (total_bits_o)
    );

    //////////////////////////////////////////////////
    // PI control codes
    //////////////////////////////////////////////////

    pi_ctl_scaler #(
        .n_outputs  (n_outputs),
        .wait_cycles(wait_cycles)
    ) u_pi_ctl (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .pi_ctl_i    (pi_ctl_i),
        .pi_offset_i (pi_offset_i),
        .max_sel_i   (max_sel_i),
        .bypass_en_i (bypass_en_i),
        .bypass_ctl_i(bypass_ctl_i),
        .ctl_valid_o (ctl_valid_o),
        .int_pi_ctl_o(int_pi_ctl_o)
    );

endmodule

// File: test/digital_core_properties.sv
`timescale 1ns/1ns

module digital_core_properties #(
    parameter int n_outputs = 4
) (
    input logic                    clk_adc,
    input logic                    cdr_rstb,
    input logic                    ctl_valid_i,
    input rx_ctl_pkg::pi_code_t    pi_code_i [n_outputs-1:0],
    input rx_data_pkg::lane_bits_t chan_sel_i,
    input logic                    clear_i,
    input rx_data_pkg::count_t     err_bits_i,
    input rx_data_pkg::count_t     total_bits_i
);
    import rx_data_pkg::*;

    logic   pi_nonzero;
    count_t sel_count;
    int     n_fail = 0;

    always_comb begin
        pi_nonzero = 1'b0;
        for (int j = 0; j < n_outputs; j++) begin
            pi_nonzero = pi_nonzero | (|pi_code_i[j]);
        end
    end

    assign sel_count = count_t'($countones(chan_sel_i));

    valid_sticky: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_i |=> ctl_valid_i)
        else begin
            n_fail++;
            $error("ctl_valid_o fell while out of reset");
        end

    pi_zero_until_valid: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        !ctl_valid_i |-> !pi_nonzero)
        else begin
            n_fail++;
            $error("int_pi_ctl_o is not zero while ctl_valid_o is low");
        end

    // a word adds nothing or one bit per selected lane
    total_step: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        !clear_i |=> (total_bits_i == $past(total_bits_i)) ||
            (total_bits_i == $past(total_bits_i) + $past(sel_count)))
        else begin
            n_fail++;
            $error("total_bits_o took a step other than zero or the selected lanes");
        end

    err_monotonic: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        !clear_i |=> err_bits_i >= $past(err_bits_i))
        else begin
            n_fail++;
            $error("err_bits_o decreased without a clear");
        end

endmodule

bind digital_core digital_core_properties #(
    .n_outputs(n_outputs)
) u_props (
    .clk_adc     (clk_adc),
    .cdr_rstb    (cdr_rstb),
    .ctl_valid_i (ctl_valid_o),
    .pi_code_i   (int_pi_ctl_o),
    .chan_sel_i  (prbs_chan_sel_i),
    .clear_i     (prbs_clear_i),
    .err_bits_i  (err_bits_o),
    .total_bits_i(total_bits_o)
);

// File: test/digital_core_tb.sv
`timescale 1ns/1ns

module digital_core_tb;
    import rx_data_pkg::*;
    import rx_ctl_pkg::*;

    localparam int n_rows    = 160;
    localparam int rst_len   = 10;
    localparam int cyc_limit = n_rows + rst_len + 64;

    typedef struct packed {
        lane_bits_t           err_mask;
        lane_bits_t           sign;
        adc_mag_t [n_ti-1:0]  mag;
        adc_code_t [n_ti-1:0] offset;
        adc_code_t            thresh;
        lane_bits_t           chan_sel;
        logic                 cke;
        logic                 clear;
        pi_code_t [n_out-1:0] pi_ctl;
        pi_code_t [n_out-1:0] pi_off;
        pi_sel_t [n_out-1:0]  max_sel;
        logic [n_out-1:0]     byp_en;
        pi_code_t [n_out-1:0] byp_ctl;
        pi_code_t [n_out-1:0] exp_pi;
    } row_t;

    logic clk_adc;
    logic cdr_rstb;
    adc_mag_t adc_mag_i [n_ti-1:0];
    lane_bits_t adc_sign_i;
    adc_code_t pfd_offset_i [n_ti-1:0];
    adc_code_t slice_thresh_i;
    prbs_eqn_t prbs_eqn_i;
    lane_bits_t prbs_chan_sel_i;
    logic prbs_cke_i;
    logic prbs_clear_i;
    pi_code_t pi_ctl_i [n_out-1:0];
    pi_code_t pi_offset_i [n_out-1:0];
    pi_sel_t max_sel_i [n_out-1:0];
    logic [n_out-1:0] bypass_en_i;
    pi_code_t bypass_ctl_i [n_out-1:0];
    lane_bits_t rx_bits_o;
    lane_bits_t prbs_flags_o;
    count_t err_bits_o;
    count_t total_bits_o;
    logic ctl_valid_o;
    pi_code_t int_pi_ctl_o [n_out-1:0];

    row_t table_q [n_rows];
    logic [31:0] lfsr;
    int n_err_bits = 0;
    int n_err_count = 0;
    int n_err_pi = 0;
    int n_err_valid = 0;
    int cyc_cnt = 0;
    int edge_cnt = 0;

    // reference model state
    adc_code_t m_unf [n_ti];
    lane_bits_t m_bits;
    lane_bits_t m_flags;
    count_t m_err;
    count_t m_total;
    logic [n_prbs-1:0] m_hist;
    chk_state_t m_state;
    pi_code_t m_pi [n_out];
    logic m_valid;

    digital_core dut (.*);

    ////////////////////////////////////////////////////
    // stimulus and reference rules
    ////////////////////////////////////////////////////

    // galois lfsr, x^32+x^22+x^2+x+1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic adc_code_t unfold_code(adc_mag_t mag, logic sign, adc_code_t off);
        int v;
        v = sign ? int'(mag) : -int'(mag);
        v = v - int'(off);
        if (v > 127) v = 127;
        if (v < -128) v = -128;
        return adc_code_t'(v);
    endfunction

    function automatic pi_code_t pi_expect(pi_code_t ctl, pi_code_t off, pi_sel_t sel,
                                           logic byp, pi_code_t byp_code);
        int code;
        int scale;
        if (byp) return byp_code;
        code  = (int'(ctl) + int'(off)) % (1 << n_pi);
        scale = (int'(sel) + 1) * 16 - 1;
        return pi_code_t'((code * scale) >> n_pi);
    endfunction

    // rows 40..119 carry prbs7, errors injected from row 80
    task automatic build_table();
        logic [n_prbs-1:0] gen;
        logic bit_v;
        row_t r;
        gen = '1;
        for (int i = 0; i < n_rows; i++) begin
            r = '0;
            r.chan_sel = '1;
            r.cke = 1'b1;
            for (int k = 0; k < n_ti; k++) r.mag[k] = adc_mag_t'(take_bits(n_adc));
            if (i >= 40 && i < 120) begin
                if (i >= 80 && i % 2 == 0) r.err_mask = lane_bits_t'(1) << take_bits(4);
                for (int k = 0; k < n_ti; k++) begin
                    bit_v = gen[5] ^ gen[6];
                    gen = {gen[n_prbs-2:0], bit_v};
                    r.sign[k] = bit_v ^ r.err_mask[k];
                    r.mag[k] = r.mag[k] | 1'b1;
                end
            end else begin
                r.sign = lane_bits_t'(take_bits(n_ti));
                r.thresh = adc_code_t'(take_bits(n_adc));
                for (int k = 0; k < n_ti; k++) r.offset[k] = adc_code_t'(take_bits(n_adc));
            end
            if (i >= 95 && i < 100) r.chan_sel = lane_bits_t'(take_bits(n_ti));
            if (i >= 100 && i < 104) r.cke = 1'b0;
            r.clear = (i == 41 || i == 110);
            for (int j = 0; j < n_out; j++) begin
                r.pi_ctl[j]  = pi_code_t'(take_bits(n_pi));
                r.pi_off[j]  = pi_code_t'(take_bits(n_pi));
                r.max_sel[j] = pi_sel_t'(take_bits(n_pi - 4));
                r.byp_en[j]  = (take_bits(2) == 0);
                r.byp_ctl[j] = pi_code_t'(take_bits(n_pi));
                r.exp_pi[j]  = pi_expect(r.pi_ctl[j], r.pi_off[j], r.max_sel[j],
                                         r.byp_en[j], r.byp_ctl[j]);
            end
            table_q[i] = r;
        end
    endtask

    task automatic drive_row(row_t r);
        for (int k = 0; k < n_ti; k++) begin
            adc_mag_i[k] = r.mag[k];
            pfd_offset_i[k] = r.offset[k];
        end
        for (int j = 0; j < n_out; j++) begin
            pi_ctl_i[j] = r.pi_ctl[j];
            pi_offset_i[j] = r.pi_off[j];
            max_sel_i[j] = r.max_sel[j];
            bypass_ctl_i[j] = r.byp_ctl[j];
        end
        adc_sign_i = r.sign;
        slice_thresh_i = r.thresh;
        prbs_chan_sel_i = r.chan_sel;
        prbs_cke_i = r.cke;
        prbs_clear_i = r.clear;
        bypass_en_i = r.byp_en;
    endtask

    // one clock edge of the reference, checker first so it sees the old word
    task automatic step_model(row_t r);
        lane_bits_t flags;
        logic pred;
        if (r.clear) begin
            m_state = CHK_FILL;
            m_flags = '0;
            m_err = '0;
            m_total = '0;
        end else if (r.cke) begin
            for (int k = 0; k < n_ti; k++) begin
                pred = 1'b0;
                for (int t = 1; t <= n_prbs; t++) begin
                    if (prbs_eqn_i[t-1]) pred = pred ^ m_hist[t-1];
                end
                flags[k] = pred ^ m_bits[k];
                m_hist = {m_hist[n_prbs-2:0], m_bits[k]};
            end
            if (m_state == CHK_RUN) begin
                m_flags = flags;
                m_err = m_err + count_t'($countones(flags & r.chan_sel));
                m_total = m_total + count_t'($countones(r.chan_sel));
            end
            m_state = CHK_RUN;
        end
        for (int k = 0; k < n_ti; k++) m_bits[k] = (m_unf[k] > adc_code_t'(r.thresh));
        for (int k = 0; k < n_ti; k++) m_unf[k] = unfold_code(r.mag[k], r.sign[k], r.offset[k]);
        edge_cnt++;
        m_valid = (edge_cnt >= 32);
        for (int j = 0; j < n_out; j++) m_pi[j] = m_valid ? r.exp_pi[j] : '0;
    endtask

    ////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////

    task automatic check_bits(string name, lane_bits_t got, lane_bits_t exp);
        if (got !== exp) begin
            n_err_bits++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, count_t got, count_t exp);
        if (got !== exp) begin
            n_err_count++;
            $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_pi(string name, pi_code_t got, pi_code_t exp);
        if (got !== exp) begin
            n_err_pi++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(logic got, logic exp);
        if (got !== exp) begin
            n_err_valid++;
            $display("Fail %0t ctl_valid_o got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_bits("rx_bits_o", rx_bits_o, m_bits);
        check_bits("prbs_flags_o", prbs_flags_o, m_flags);
        check_count("err_bits_o", err_bits_o, m_err);
        check_count("total_bits_o", total_bits_o, m_total);
        check_valid(ctl_valid_o, m_valid);
        for (int j = 0; j < n_out; j++) begin
            check_pi($sformatf("int_pi_ctl_o[%0d]", j), int_pi_ctl_o[j], m_pi[j]);
        end
    endtask

    ////////////////////////////////////////////////////
    // clock, limit and main sequence
    ////////////////////////////////////////////////////

    initial begin
        clk_adc = 1'b0;
        forever #5 clk_adc = ~clk_adc;
    end

    always @(posedge clk_adc) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= cyc_limit) begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cyc_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        row_t cur;
        lfsr = 32'h2787_0b37;
        cdr_rstb = 1'b0;
        prbs_eqn_i = 7'h60;
        drive_row('0);
        m_unf = '{default: '0};
        m_pi = '{default: '0};
        m_bits = '0;
        m_flags = '0;
        m_err = '0;
        m_total = '0;
        m_hist = '0;
        m_state = CHK_FILL;
        m_valid = 1'b0;
        build_table();
        repeat (rst_len) @(posedge clk_adc);
        #1;
        cdr_rstb = 1'b1;
        cur = table_q[0];
        drive_row(cur);
        // everything still at its reset value
        compare_outputs();
        for (int i = 1; i <= n_rows + 3; i++) begin
            @(posedge clk_adc);
            step_model(cur);
            #1;
            if (i < n_rows) cur = table_q[i];
            drive_row(cur);
            @(negedge clk_adc);
            compare_outputs();
            // clean prbs7 words 41..79 are all counted by now
            if (i == 82) begin
                check_count("err_bits_o", err_bits_o, '0);
                check_count("total_bits_o", total_bits_o, count_t'(16 * 39));
            end
        end
        $display("errors: bits %0d, counts %0d, pi %0d, valid %0d, assertions %0d",
                 n_err_bits, n_err_count, n_err_pi, n_err_valid, dut.u_props.n_fail);
        if (n_err_bits + n_err_count + n_err_pi + n_err_valid + dut.u_props.n_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
source/rx_data_pkg.sv
source/rx_ctl_pkg.sv
source/adc_unfold_slice.sv
source/prbs_checker.sv
source/pi_ctl_scaler.sv
source/digital_core.sv
test/digital_core_properties.sv
test/digital_core_tb.sv

// File: Bender.yml
package:
  name: digital_core

sources:
  - files:
      - source/rx_data_pkg.sv
      - source/rx_ctl_pkg.sv
      - source/adc_unfold_slice.sv
      - source/prbs_checker.sv
      - source/pi_ctl_scaler.sv
      - source/digital_core.sv
  - target: test
    files:
      - test/digital_core_properties.sv
      - test/digital_core_tb.sv
